// File: Bender.yml
package:
  name: i2c_master

sources:
  - files:
      - hw/i2c_pkg.sv
      - hw/i2c_bit_if.sv
      - hw/i2c_tick_sync.sv
      - hw/i2c_transaction_seq.sv
      - hw/i2c_bit_engine.sv
      - hw/i2c_master_top.sv
  - target: test
    files:
      - testbench/i2c_target_model.sv
      - testbench/tb_i2c_master.sv

// File: files.f
hw/i2c_pkg.sv
hw/i2c_bit_if.sv
hw/i2c_tick_sync.sv
hw/i2c_transaction_seq.sv
hw/i2c_bit_engine.sv
hw/i2c_master_top.sv
testbench/i2c_target_model.sv
testbench/tb_i2c_master.sv

// File: hw/i2c_bit_engine.sv
// Bit engine: plays one bus symbol over four quarter-bit ticks.
// Lines are open drain, so it only pulls low or releases.
// A target may stretch SCL in the second phase up to a tick limit.
`timescale 1ns/1ps

module i2c_bit_engine #(
    parameter int STRETCH_MAX_TICKS = 255
) (
    input  logic      clock,
    input  logic      safe_reset_n,
    input  logic      tick,
    input  logic      scl_in,
    input  logic      sda_in,
    output logic      scl_low,
    output logic      sda_low,
    i2c_bit_if.engine bus
);

    localparam int PHASE_BITS   = $clog2(i2c_pkg::PHASE_COUNT);
    localparam int STRETCH_BITS = $clog2(STRETCH_MAX_TICKS + 1);

    localparam logic [PHASE_BITS-1:0]   LAST_PHASE    = PHASE_BITS'(i2c_pkg::PHASE_COUNT - 1);
    localparam logic [STRETCH_BITS-1:0] STRETCH_LIMIT = STRETCH_BITS'(STRETCH_MAX_TICKS);

    logic                    active;
    logic [PHASE_BITS-1:0]   phase;
    i2c_pkg::bus_cmd_e       cmd_q;
    logic [STRETCH_BITS-1:0] stretch_cnt;

    assign bus.done    = active && tick && (phase == LAST_PHASE);
    // scl still held low by the target once the limit is used up
    assign bus.aborted = active && tick && (phase == 2'd1) && !scl_in &&
                         (stretch_cnt == STRETCH_LIMIT);

    // ==================================================
    // phase sequencing
    // ==================================================
    always_ff @(posedge clock or negedge safe_reset_n) begin
        if (!safe_reset_n) begin
            active      <= 1'b0;
            phase       <= '0;
            cmd_q       <= i2c_pkg::cmd_start;
            stretch_cnt <= '0;
            scl_low     <= 1'b0;
            sda_low     <= 1'b0;
            bus.rx_bit  <= 1'b1;
        end else if (!active) begin
            if (bus.cmd_valid) begin
                active      <= 1'b1;
                phase       <= '0;
                cmd_q       <= bus.cmd;
                stretch_cnt <= '0;
                // sda is set up while scl is still low
                case (bus.cmd)
                    i2c_pkg::cmd_start, i2c_pkg::cmd_restart: sda_low <= 1'b0;
                    i2c_pkg::cmd_stop:                        sda_low <= 1'b1;
                    default:                                  sda_low <= !bus.tx_bit;
                endcase
            end
        end else if (tick) begin
            case (phase)
                2'd0: begin
                    scl_low <= 1'b0;
                    phase   <= 2'd1;
                end
                2'd1: begin
                    if (scl_in) begin
                        phase <= 2'd2;
                        // start condition, sda falls while scl is high
                        if (cmd_q == i2c_pkg::cmd_start || cmd_q == i2c_pkg::cmd_restart) begin
                            sda_low <= 1'b1;
                        end
                    end else if (stretch_cnt == STRETCH_LIMIT) begin
                        // give up without a stop
                        active  <= 1'b0;
                        scl_low <= 1'b0;
                        sda_low <= 1'b0;
                    end else begin
                        stretch_cnt <= stretch_cnt + 1'b1;
                    end
                end
                2'd2: begin
                    phase <= LAST_PHASE;
                    if (cmd_q == i2c_pkg::cmd_bit) begin
                        bus.rx_bit <= sda_in;
                    end
                    // stop condition, sda rises while scl is high
                    if (cmd_q == i2c_pkg::cmd_stop) begin
                        sda_low <= 1'b0;
                    end
                end
                default: begin
                    active <= 1'b0;
                    if (cmd_q != i2c_pkg::cmd_stop) begin
                        scl_low <= 1'b1;
                    end
                end
            endcase
        end
    end

    // data bits may only move while scl is held low
    sda_stable_in_bit: assert property (
        @(posedge clock) disable iff (!safe_reset_n)
        $changed(sda_low) && (cmd_q == i2c_pkg::cmd_bit) && !$past(bus.aborted)
            |-> scl_low
    );

endmodule

// File: hw/i2c_bit_if.sv
// Command link between the transaction sequencer and the bit engine.
// One strobe per bus symbol; the engine answers with done or aborted.
`timescale 1ns/1ps

interface i2c_bit_if;

    // sequencer to engine
    logic               cmd_valid;
    i2c_pkg::bus_cmd_e  cmd;
    // 1 releases sda, 0 pulls it low
    logic               tx_bit;

    // engine to sequencer
    logic               done;
    logic               rx_bit;
    logic               aborted;

    modport seq (
        output cmd_valid,
        output cmd,
        output tx_bit,
        input  done,
        input  rx_bit,
        input  aborted
    );

    modport engine (
        input  cmd_valid,
        input  cmd,
        input  tx_bit,
        output done,
        output rx_bit,
        output aborted
    );

endinterface

// File: hw/i2c_master_top.sv
// Top level of the I2C register-access controller.
// Chains tick sync, sequencer and bit engine, and builds open-drain pads.
`timescale 1ns/1ps

module i2c_master_top #(
    parameter int DATA_BYTES        = 1,
    parameter int REG_BYTES         = 1,
    parameter int STRETCH_MAX_TICKS = 255
) (
    input  logic                                      clock,
    input  logic                                      safe_reset_n,
    input  logic                                      ref_clock,
    input  logic                                      enable,
    input  logic                                      read_write,
    input  logic [i2c_pkg::ADDR_WIDTH-1:0]            device_address,
    input  logic [REG_BYTES*i2c_pkg::BYTE_BITS-1:0]   register_address,
    input  logic [DATA_BYTES*i2c_pkg::BYTE_BITS-1:0]  write_data,
    output logic [DATA_BYTES*i2c_pkg::BYTE_BITS-1:0]  read_data,
    output logic                                      busy,
    inout  wire                                       sda,
    inout  wire                                       scl
);

    logic tick;
    logic scl_low;
    logic sda_low;

    i2c_bit_if bus_if ();

    i2c_tick_sync i2c_tick_sync_i (
        .clock        (clock),
        .safe_reset_n (safe_reset_n),
        .ref_clock    (ref_clock),
        .tick         (tick)
    );

    i2c_transaction_seq #(
        .DATA_BYTES (DATA_BYTES),
        .REG_BYTES  (REG_BYTES)
    ) i2c_transaction_seq_i (
        .clock            (clock),
        .safe_reset_n     (safe_reset_n),
        .enable           (enable),
        .read_write       (read_write),
        .device_address   (device_address),
        .register_address (register_address),
        .write_data       (write_data),
        .read_data        (read_data),
        .busy             (busy),
        .bus              (bus_if.seq)
    );

    i2c_bit_engine #(
        .STRETCH_MAX_TICKS (STRETCH_MAX_TICKS)
    ) i2c_bit_engine_i (
        .clock        (clock),
        .safe_reset_n (safe_reset_n),
        .tick         (tick),
        .scl_in       (scl),
        .sda_in       (sda),
        .scl_low      (scl_low),
        .sda_low      (sda_low),
        .bus          (bus_if.engine)
    );

    // pull low or float, external pull-ups give the high level
    assign scl = scl_low ? 1'b0 : 1'bz;
    assign sda = sda_low ? 1'b0 : 1'bz;

endmodule

// File: hw/i2c_pkg.sv
// Shared definitions for the I2C register-access controller.
// Compile this package first; the RTL refers to it by scoped names.
package i2c_pkg;

    // ==================================================
    // bus geometry
    // ==================================================
    localparam int ADDR_WIDTH  = 7;
    localparam int BYTE_BITS   = 8;
    // quarter-bit ticks in one bus symbol
    localparam int PHASE_COUNT = 4;

    // ==================================================
    // symbol requested from the bit engine
    // ==================================================
    typedef enum logic [1:0] {
        cmd_start   = 2'd0,
        cmd_restart = 2'd1,
        cmd_stop    = 2'd2,
        cmd_bit     = 2'd3
    } bus_cmd_e;

    // first byte after a start or repeated start
    // built by fields, shifted out as a raw byte
    typedef union packed {
        logic [BYTE_BITS-1:0] raw;
        struct packed {
            logic [ADDR_WIDTH-1:0] device;
            logic                  rw;
        } fields;
    } addr_byte_u;

endpackage

// File: hw/i2c_tick_sync.sv
// Brings the bus reference clock into the system clock domain.
// Each falling edge gives a one-cycle quarter-bit tick.
`timescale 1ns/1ps

module i2c_tick_sync (
    input  logic clock,
    input  logic safe_reset_n,
    input  logic ref_clock,
    output logic tick
);

    // idle level of the reference is assumed high
    logic [2:0] ref_sync;

    always_ff @(posedge clock or negedge safe_reset_n) begin
        if (!safe_reset_n) begin
            ref_sync <= 3'b111;
            tick     <= 1'b0;
        end else begin
            ref_sync <= {ref_sync[1:0], ref_clock};
            // high to low on the two oldest stages
            tick     <= ref_sync[2] & ~ref_sync[1];
        end
    end

    // the reference is far slower than clock, so ticks stay apart
    tick_single_cycle: assert property (
        @(posedge clock) disable iff (!safe_reset_n)
        tick |-> !$past(tick) && !$past(tick, 2)
    );

endmodule

// File: hw/i2c_transaction_seq.sv
// Transaction sequencer for register writes and reads on the I2C bus.
// Captures a request on enable and issues one bus symbol per command
// to the bit engine until the closing stop, a nack or an abort.
`timescale 1ns/1ps

module i2c_transaction_seq #(
    parameter int DATA_BYTES = 1,
    parameter int REG_BYTES  = 1
) (
    input  logic                                      clock,
    input  logic                                      safe_reset_n,
    input  logic                                      enable,
    input  logic                                      read_write,
    input  logic [i2c_pkg::ADDR_WIDTH-1:0]            device_address,
    input  logic [REG_BYTES*i2c_pkg::BYTE_BITS-1:0]   register_address,
    input  logic [DATA_BYTES*i2c_pkg::BYTE_BITS-1:0]  write_data,
    output logic [DATA_BYTES*i2c_pkg::BYTE_BITS-1:0]  read_data,
    output logic                                      busy,
    i2c_bit_if.seq                                    bus
);

    localparam int BYTE_BITS  = i2c_pkg::BYTE_BITS;
    localparam int REG_W      = REG_BYTES * BYTE_BITS;
    localparam int DATA_W     = DATA_BYTES * BYTE_BITS;
    localparam int MAX_BYTES  = (DATA_BYTES > REG_BYTES) ? DATA_BYTES : REG_BYTES;
    localparam int COUNT_BITS = $clog2(MAX_BYTES + 1);
    localparam int BIT_BITS   = $clog2(BYTE_BITS);

    localparam logic [BIT_BITS-1:0]   BIT_LAST  = BIT_BITS'(BYTE_BITS - 1);
    localparam logic [COUNT_BITS-1:0] REG_LAST  = COUNT_BITS'(REG_BYTES - 1);
    localparam logic [COUNT_BITS-1:0] DATA_LAST = COUNT_BITS'(DATA_BYTES - 1);

    // sequencer states
    localparam logic [3:0] ST_IDLE    = 4'd0;
    localparam logic [3:0] ST_START   = 4'd1;
    localparam logic [3:0] ST_ADDR_W  = 4'd2;
    localparam logic [3:0] ST_REG     = 4'd3;
    localparam logic [3:0] ST_DATA    = 4'd4;
    localparam logic [3:0] ST_RESTART = 4'd5;
    localparam logic [3:0] ST_ADDR_R  = 4'd6;
    localparam logic [3:0] ST_ACK     = 4'd7;
    localparam logic [3:0] ST_READ    = 4'd8;
    localparam logic [3:0] ST_MACK    = 4'd9;
    localparam logic [3:0] ST_STOP    = 4'd10;

    logic [3:0]                state;
    // byte state whose ack is being checked
    logic [3:0]                sent_q;
    logic [BIT_BITS-1:0]       bit_cnt;
    logic [COUNT_BITS-1:0]     byte_cnt;
    logic                      rw_q;
    i2c_pkg::addr_byte_u       addr_q;
    logic [BYTE_BITS-1:0]      shift_q;
    logic [REG_W-1:0]          reg_q;
    logic [DATA_W-1:0]         data_q;

    assign busy = (state != ST_IDLE);

    // ==================================================
    // symbol for the current state
    // ==================================================
    always_comb begin
        bus.cmd    = i2c_pkg::cmd_bit;
        bus.tx_bit = 1'b1;
        case (state)
            ST_START:   bus.cmd = i2c_pkg::cmd_start;
            ST_RESTART: bus.cmd = i2c_pkg::cmd_restart;
            ST_STOP:    bus.cmd = i2c_pkg::cmd_stop;
            ST_ADDR_W, ST_REG, ST_DATA, ST_ADDR_R: begin
                bus.tx_bit = shift_q[BYTE_BITS-1];
            end
            // nack only after the last read byte
            ST_MACK:    bus.tx_bit = (byte_cnt == '0);
            default:    bus.cmd = i2c_pkg::cmd_bit;
        endcase
    end

    // ==================================================
    // transaction FSM
    // ==================================================
    always_ff @(posedge clock or negedge safe_reset_n) begin
        if (!safe_reset_n) begin
            state         <= ST_IDLE;
            sent_q        <= ST_IDLE;
            bit_cnt       <= '0;
            byte_cnt      <= '0;
            rw_q          <= 1'b0;
            bus.cmd_valid <= 1'b0;
            addr_q        <= '0;
            shift_q       <= '0;
            reg_q         <= '0;
            data_q        <= '0;
            read_data     <= '0;
        end else begin
            bus.cmd_valid <= 1'b0;
            if (state == ST_IDLE) begin
                if (enable) begin
                    state                <= ST_START;
                    bus.cmd_valid        <= 1'b1;
                    rw_q                 <= read_write;
                    addr_q.fields.device <= device_address;
                    addr_q.fields.rw     <= 1'b0;
                    reg_q                <= register_address;
                    data_q               <= write_data;
                end
            end else if (bus.aborted) begin
                // lines already released by the engine
                state <= ST_IDLE;
            end else if (bus.done) begin
                bus.cmd_valid <= (state != ST_STOP);
                case (state)
                    ST_START, ST_RESTART: begin
                        shift_q <= addr_q.raw;
                        bit_cnt <= BIT_LAST;
                        state   <= (state == ST_START) ? ST_ADDR_W : ST_ADDR_R;
                    end
                    ST_ADDR_W, ST_REG, ST_DATA, ST_ADDR_R: begin
                        shift_q <= shift_q << 1;
                        bit_cnt <= bit_cnt - 1'b1;
                        if (bit_cnt == '0) begin
                            sent_q <= state;
                            state  <= ST_ACK;
                        end
                    end
                    ST_ACK: begin
                        bit_cnt <= BIT_LAST;
                        if (bus.rx_bit) begin
                            // target nack
                            state <= ST_STOP;
                        end else begin
                            case (sent_q)
                                ST_ADDR_W: begin
                                    shift_q  <= reg_q[REG_W-1 -: BYTE_BITS];
                                    reg_q    <= reg_q << BYTE_BITS;
                                    byte_cnt <= REG_LAST;
                                    state    <= ST_REG;
                                end
                                ST_REG: begin
                                    if (byte_cnt != '0) begin
                                        shift_q  <= reg_q[REG_W-1 -: BYTE_BITS];
                                        reg_q    <= reg_q << BYTE_BITS;
                                        byte_cnt <= byte_cnt - 1'b1;
                                        state    <= ST_REG;
                                    end else if (rw_q) begin
                                        addr_q.fields.rw <= 1'b1;
                                        state            <= ST_RESTART;
                                    end else begin
                                        shift_q  <= data_q[DATA_W-1 -: BYTE_BITS];
                                        data_q   <= data_q << BYTE_BITS;
                                        byte_cnt <= DATA_LAST;
                                        state    <= ST_DATA;
                                    end
                                end
                                ST_DATA: begin
                                    if (byte_cnt != '0) begin
                                        shift_q  <= data_q[DATA_W-1 -: BYTE_BITS];
                                        data_q   <= data_q << BYTE_BITS;
                                        byte_cnt <= byte_cnt - 1'b1;
                                        state    <= ST_DATA;
                                    end else begin
                                        state <= ST_STOP;
                                    end
                                end
                                default: begin
                                    // read address acked
                                    byte_cnt <= DATA_LAST;
                                    state    <= ST_READ;
                                end
                            endcase
                        end
                    end
                    ST_READ: begin
                        read_data <= {read_data[DATA_W-2:0], bus.rx_bit};
                        bit_cnt   <= bit_cnt - 1'b1;
                        if (bit_cnt == '0) begin
                            state <= ST_MACK;
                        end
                    end
                    ST_MACK: begin
                        bit_cnt <= BIT_LAST;
                        if (byte_cnt == '0) begin
                            state <= ST_STOP;
                        end else begin
                            byte_cnt <= byte_cnt - 1'b1;
                            state    <= ST_READ;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    cmd_only_while_busy: assert property (
        @(posedge clock) disable iff (!safe_reset_n)
        bus.cmd_valid |-> busy
    );

endmodule

// File: testbench/i2c_target_model.sv
// Behavioral I2C target with a 256-byte register memory.
// Acks its own address, auto-increments the register pointer inside a
// transaction, and can hold SCL low after every acked byte.
`timescale 1ns/1ps

module i2c_target_model #(
    parameter logic [6:0] DEVICE_ADDRESS = 7'h50
) (
    inout wire sda,
    inout wire scl,
    input int  stretch_ns
);

    localparam int MODE_IDLE  = 0;
    localparam int MODE_ADDR  = 1;
    localparam int MODE_REG   = 2;
    localparam int MODE_WRITE = 3;
    localparam int MODE_READ  = 4;

    logic [7:0] mem [0:255];
    logic       sda_pull = 1'b0;
    logic       scl_pull = 1'b0;
    int         mode = MODE_IDLE;
    // bits seen in the current byte, 8 and 9 mark the ack slot
    int         bit_idx = 0;
    logic [7:0] shift_byte = '0;
    logic [7:0] tx_byte = '0;
    logic [7:0] reg_ptr = '0;
    logic       read_mode = 1'b0;
    logic       master_nack = 1'b0;

    assign sda = sda_pull ? 1'b0 : 1'bz;
    assign scl = scl_pull ? 1'b0 : 1'bz;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'hA5;
        end
    end

    // start or repeated start
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            mode     = MODE_ADDR;
            bit_idx  = 0;
            sda_pull = 1'b0;
        end
    end

    // stop
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            mode = MODE_IDLE;
        end
    end

    always @(posedge scl) begin
        if (mode != MODE_IDLE) begin
            if (bit_idx < 8) begin
                shift_byte = {shift_byte[6:0], sda};
                bit_idx    = bit_idx + 1;
            end else if (bit_idx == 8) begin
                master_nack = sda;
                bit_idx     = 9;
            end
        end
    end

    always @(negedge scl) begin
        if (mode != MODE_IDLE) begin
            if (bit_idx == 8) begin
                // byte complete, answer in the ack slot
                case (mode)
                    MODE_ADDR: begin
                        read_mode = shift_byte[0];
                        if (shift_byte[7:1] == DEVICE_ADDRESS) begin
                            sda_pull = 1'b1;
                        end else begin
                            mode = MODE_IDLE;
                        end
                    end
                    MODE_REG: begin
                        reg_ptr  = shift_byte;
                        sda_pull = 1'b1;
                    end
                    MODE_WRITE: begin
                        mem[reg_ptr] = shift_byte;
                        reg_ptr      = reg_ptr + 8'd1;
                        sda_pull     = 1'b1;
                    end
                    default: sda_pull = 1'b0;
                endcase
            end else if (bit_idx == 9) begin
                sda_pull = 1'b0;
                bit_idx  = 0;
                case (mode)
                    MODE_ADDR: mode = read_mode ? MODE_READ : MODE_REG;
                    MODE_REG:  mode = MODE_WRITE;
                    MODE_READ: mode = master_nack ? MODE_IDLE : MODE_READ;
                    default:   mode = mode;
                endcase
                if (mode == MODE_READ) begin
                    tx_byte  = mem[reg_ptr];
                    reg_ptr  = reg_ptr + 8'd1;
                    sda_pull = !tx_byte[7];
                end
                // clock stretch after the ack
                if (mode != MODE_IDLE && stretch_ns > 0) begin
                    scl_pull = 1'b1;
                    #(stretch_ns);
                    scl_pull = 1'b0;
                end
            end else if (mode == MODE_READ && bit_idx > 0) begin
                sda_pull = !tx_byte[7 - bit_idx];
            end
        end
    end

endmodule

// File: testbench/tb_i2c_master.sv
// Testbench for the I2C register-access controller.
// Runs writes and reads against a behavioral target, with and without
// clock stretching, and checks read data against a shadow memory.
`timescale 1ns/1ps

module tb_i2c_master;

    localparam logic [6:0] TARGET_ADDRESS = 7'h50;
    // one quarter-bit tick of the scaled reference clock
    localparam int TICK_NS      = 400;
    localparam int BUSY_TIMEOUT = 40000;
    localparam int SCL_TIMEOUT  = 5000;

    logic        clock = 1'b0;
    logic        ref_clock = 1'b1;
    logic        safe_reset_n = 1'b0;
    logic        enable = 1'b0;
    logic        read_write = 1'b0;
    logic [6:0]  device_address = '0;
    logic [7:0]  register_address = '0;
    logic [15:0] write_data = '0;
    logic [15:0] read_data;
    logic        busy;
    tri1         sda;
    tri1         scl;
    int          stretch_ns = 0;

    integer      seed = 87396;
    logic [7:0]  shadow [0:255];
    int          checks = 0;
    int          errors = 0;
    logic        check_req = 1'b0;
    logic [15:0] check_expected = '0;
    string       check_name = "";

    always #5 clock = ~clock;
    // reference clock scaled down for simulation
    always #200 ref_clock = ~ref_clock;

    i2c_master_top #(
        .DATA_BYTES        (2),
        .REG_BYTES         (1),
        .STRETCH_MAX_TICKS (8)
    ) i2c_master_top_i (
        .clock            (clock),
        .safe_reset_n     (safe_reset_n),
        .ref_clock        (ref_clock),
        .enable           (enable),
        .read_write       (read_write),
        .device_address   (device_address),
        .register_address (register_address),
        .write_data       (write_data),
        .read_data        (read_data),
        .busy             (busy),
        .sda              (sda),
        .scl              (scl)
    );

    i2c_target_model #(
        .DEVICE_ADDRESS (TARGET_ADDRESS)
    ) i2c_target_model_i (
        .sda        (sda),
        .scl        (scl),
        .stretch_ns (stretch_ns)
    );

    // ==================================================
    // reference model
    // ==================================================
    // first byte read lands in the upper half
    function automatic logic [15:0] expected_read(input logic [7:0] reg_index);
        logic [7:0] next_index;
        next_index = reg_index + 8'd1;
        return {shadow[reg_index], shadow[next_index]};
    endfunction

    task automatic record_write(input logic [7:0] reg_index, input logic [15:0] data);
        logic [7:0] next_index;
        next_index         = reg_index + 8'd1;
        shadow[reg_index]  = data[15:8];
        shadow[next_index] = data[7:0];
    endtask

    // checker, compares one cycle after a request
    always @(posedge clock) begin
        if (check_req) begin
            checks = checks + 1;
            assert (read_data === check_expected) else begin
                $display("ERR t=%0t read_data got %h expected %h in %s",
                         $time, read_data, check_expected, check_name);
                errors = errors + 1;
            end
        end
    end

    task automatic check_read_data(input logic [15:0] expected, input string what);
        @(posedge clock);
        check_expected <= expected;
        check_name     <= what;
        check_req      <= 1'b1;
        @(posedge clock);
        check_req <= 1'b0;
        @(posedge clock);
    endtask

    // ==================================================
    // bus driving and waits
    // ==================================================
    task automatic wait_busy(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (busy !== level && cycles < BUSY_TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        if (busy !== level) begin
            $display("timeout: busy never went to %0d during %s", level, what);
            $display("=== FAIL ===");
            $finish;
        end
    endtask

    task automatic wait_scl_released();
        int cycles;
        cycles = 0;
        while (scl !== 1'b1 && cycles < SCL_TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        if (scl !== 1'b1) begin
            $display("timeout: target kept scl low after the aborted transfer");
            $display("=== FAIL ===");
            $finish;
        end
    endtask

    task automatic send_request(input logic rw, input logic [6:0] dev,
                                input logic [7:0] reg_index, input logic [15:0] data);
        @(posedge clock);
        enable           <= 1'b1;
        read_write       <= rw;
        device_address   <= dev;
        register_address <= reg_index;
        write_data       <= data;
        @(posedge clock);
        enable <= 1'b0;
    endtask

    task automatic run_transaction(input logic rw, input logic [6:0] dev,
                                   input logic [7:0] reg_index, input logic [15:0] data,
                                   input string what);
        send_request(rw, dev, reg_index, data);
        wait_busy(1'b1, what);
        wait_busy(1'b0, what);
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: FAILED", name);
        end
    endtask

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        logic [7:0]  reg_a;
        logic [7:0]  reg_b;
        logic [15:0] data_a;
        logic [15:0] data_b;
        logic [15:0] last_read;
        int          errors_before;
        int          i;

        for (i = 0; i < 256; i++) begin
            shadow[i] = 8'(i) ^ 8'hA5;
        end
        repeat (3) @(posedge clock);
        safe_reset_n <= 1'b1;
        repeat (2) @(posedge clock);

        errors_before = errors;
        reg_a  = 8'($random(seed));
        data_a = 16'($random(seed));
        run_transaction(1'b0, TARGET_ADDRESS, reg_a, data_a, "write");
        record_write(reg_a, data_a);
        run_transaction(1'b1, TARGET_ADDRESS, reg_a, 16'h0000, "read back");
        last_read = expected_read(reg_a);
        check_read_data(last_read, "write then read back");
        report_test("write_read_back", errors_before);

        errors_before = errors;
        reg_b = reg_a + 8'h40;
        run_transaction(1'b1, TARGET_ADDRESS, reg_b, 16'h0000, "unwritten read");
        last_read = expected_read(reg_b);
        check_read_data(last_read, "unwritten register");
        report_test("unwritten_register", errors_before);

        // other address, target stays silent
        errors_before = errors;
        data_b = 16'($random(seed));
        run_transaction(1'b0, TARGET_ADDRESS ^ 7'h01, reg_b, data_b, "wrong address write");
        run_transaction(1'b1, TARGET_ADDRESS ^ 7'h01, reg_a, 16'h0000, "wrong address read");
        check_read_data(last_read, "read_data kept after nack");
        run_transaction(1'b1, TARGET_ADDRESS, reg_b, 16'h0000, "read after nack");
        last_read = expected_read(reg_b);
        check_read_data(last_read, "memory kept after nack");
        report_test("wrong_address", errors_before);

        errors_before = errors;
        stretch_ns = 3 * TICK_NS + 3;
        data_a = 16'($random(seed));
        run_transaction(1'b0, TARGET_ADDRESS, reg_a, data_a, "stretched write");
        record_write(reg_a, data_a);
        run_transaction(1'b1, TARGET_ADDRESS, reg_a, 16'h0000, "stretched read");
        last_read = expected_read(reg_a);
        check_read_data(last_read, "short stretch");
        stretch_ns = 0;
        report_test("short_stretch", errors_before);

        // beyond the limit the controller aborts, nothing is written
        errors_before = errors;
        stretch_ns = 20 * TICK_NS + 3;
        data_b = 16'($random(seed));
        run_transaction(1'b0, TARGET_ADDRESS, reg_b, data_b, "aborted write");
        stretch_ns = 0;
        wait_scl_released();
        run_transaction(1'b1, TARGET_ADDRESS, reg_b, 16'h0000, "read after abort");
        last_read = expected_read(reg_b);
        check_read_data(last_read, "long stretch");
        report_test("long_stretch", errors_before);

        errors_before = errors;
        reg_a  = 8'($random(seed));
        reg_b  = reg_a + 8'h80;
        data_a = 16'($random(seed));
        data_b = 16'($random(seed));
        send_request(1'b0, TARGET_ADDRESS, reg_a, data_a);
        wait_busy(1'b1, "first request");
        repeat (100) @(posedge clock);
        send_request(1'b0, TARGET_ADDRESS, reg_b, data_b);
        wait_busy(1'b0, "first request");
        record_write(reg_a, data_a);
        repeat (20) @(posedge clock);
        checks++;
        assert (busy === 1'b0) else begin
            $display("ERR t=%0t busy got %b expected 0", $time, busy);
            errors++;
        end
        run_transaction(1'b1, TARGET_ADDRESS, reg_a, 16'h0000, "read first target");
        check_read_data(expected_read(reg_a), "accepted request");
        run_transaction(1'b1, TARGET_ADDRESS, reg_b, 16'h0000, "read second target");
        last_read = expected_read(reg_b);
        check_read_data(last_read, "ignored request");
        report_test("enable_while_busy", errors_before);

        $display("tests done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
